//--- files.f
+incdir+tests
src/mem_bus_pkg.sv
src/write_heap_pkg.sv
src/read_channel.sv
src/write_heap.sv
src/write_beat_sequencer.sv
src/edge_fiu.sv
tests/edge_fiu_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the edge FIU testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module edge_fiu_tb \
    -f files.f \
    -o edge_fiu_sim

./obj_dir/edge_fiu_sim | tee sim.log

if grep -q "Done: errors found" sim.log; then
    echo "Simulation reported failures, see sim.log"
    exit 1
fi

echo "Simulation finished cleanly"

//--- tests/edge_fiu_model.svh
// Edge FIU reference model

`ifndef EDGE_FIU_MODEL_SVH
`define EDGE_FIU_MODEL_SVH

// Image of every line the testbench has written into the write heap
t_line heap_img [HEAP_LINES];

// A slot stays busy from its heap writes until its last flit has left
bit slot_busy [HEAP_SLOTS];

// Expected read traffic, each source kept in its own issue order
t_line_addr exp_afu_rd_addr[$];
t_mdata     exp_afu_rd_mdata[$];
t_line_addr exp_afu_rsp_addr[$];
t_mdata     exp_afu_rsp_mdata[$];
t_line_addr exp_pt_rd_addr[$];
t_line_addr exp_pt_rsp_addr[$];

// Expected write flits in request order
t_line_addr exp_flit_addr[$];
logic       exp_flit_sop[$];
t_line      exp_flit_data[$];
// Holds the slot on the last beat of a packet and -1 on the others
int         exp_flit_last_slot[$];
t_heap_slot exp_free_slot[$];

// Host memory contents are a fixed function of the line address
function automatic t_line addr_data(input t_line_addr addr);
    return {addr ^ 32'h3c5a_96e1, ~addr};
endfunction

// Beat k of a packet goes to base OR k and carries heap line (slot, k)
task automatic expect_write(input t_heap_slot slot, input t_line_addr addr, input t_beat len);
    t_heap_addr hline;
    for (int k = 0; k <= int'(len); k++)
    begin
        hline = {slot, t_beat'(k)};
        exp_flit_addr.push_back(addr | t_line_addr'(k));
        exp_flit_sop.push_back(k == 0);
        exp_flit_data.push_back(heap_img[hline]);
        exp_flit_last_slot.push_back((k == int'(len)) ? int'(slot) : -1);
    end
    // Exactly one release per packet, in request order
    exp_free_slot.push_back(slot);
endtask

// Nothing is left that the DUT still owes the testbench
function automatic bit model_drained();
    return exp_afu_rd_addr.size() == 0 && exp_afu_rsp_addr.size() == 0 &&
           exp_pt_rd_addr.size() == 0 && exp_pt_rsp_addr.size() == 0 &&
           exp_flit_addr.size() == 0 && exp_free_slot.size() == 0;
endfunction

`endif

//--- tests/edge_fiu_tb.sv
// Edge FIU testbench

`timescale 1ns/1ps

module edge_fiu_tb
    import mem_bus_pkg::*;
    import write_heap_pkg::*;
();

    localparam int CLK_PERIOD = 8;
    localparam int N_AFU_RD = 40;
    localparam int N_MIX_RD = 30;
    localparam int N_PT_RD = 8;
    localparam int N_SINGLE_WR = 12;
    localparam int N_MULTI_WR = 12;
    localparam int N_STRESS_WR = 40;
    // Generous bound on the cycles one transaction may take, stalls included
    localparam int TXN_CYCLES = 40;
    localparam int TOTAL_TXNS = N_AFU_RD + N_MIX_RD + N_PT_RD + N_SINGLE_WR
                              + N_MULTI_WR + N_STRESS_WR;

    logic        clk = 1'b0;
    logic        reset = 1'b1;
    logic        afu_rd_valid = 1'b0;
    logic        afu_rd_ready;
    t_line_addr  afu_rd_addr = '0;
    t_mdata      afu_rd_mdata = '0;
    logic        pt_rd_valid = 1'b0;
    logic        pt_rd_ready;
    t_line_addr  pt_rd_addr = '0;
    logic        fiu_rd_valid;
    logic        fiu_rd_ready = 1'b0;
    t_line_addr  fiu_rd_addr;
    t_mdata      fiu_rd_mdata;
    logic        fiu_rsp_valid = 1'b0;
    t_mdata      fiu_rsp_mdata = '0;
    t_line       fiu_rsp_data = '0;
    logic        afu_rsp_valid;
    t_mdata      afu_rsp_mdata;
    t_line       afu_rsp_data;
    logic        pt_rsp_valid;
    t_line       pt_rsp_data;
    logic        heap_wr_en = 1'b0;
    t_heap_slot  heap_wr_slot = '0;
    t_beat       heap_wr_beat = '0;
    t_line       heap_wr_data = '0;
    logic        afu_wr_valid = 1'b0;
    logic        afu_wr_ready;
    t_line_addr  afu_wr_addr = '0;
    t_beat       afu_wr_len = '0;
    t_wr_payload afu_wr_payload = '0;
    logic        fiu_wr_valid;
    logic        fiu_wr_ready = 1'b0;
    t_line_addr  fiu_wr_addr;
    logic        fiu_wr_sop;
    t_line       fiu_wr_data;
    logic        heap_free_valid;
    t_heap_slot  heap_free_slot;

    int errors = 0;
    int checks = 0;
    int cycle = 0;
    int test_num = 1;
    int test_err_start = 0;
    // Percentage of cycles on which the host takes a write flit
    int wr_ready_pct = 100;

    // Host read responses waiting for their due cycle, always returned in order
    t_line_addr rsp_addr_q[$];
    t_mdata     rsp_mdata_q[$];
    int         rsp_due_q[$];
    int         last_due = 0;

    `include "edge_fiu_model.svh"

    edge_fiu edge_fiu_i (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic report_failure(input string msg);
        errors++;
        $display("Failure at %0t ns: %s", $time, msg);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n)
        begin
            @(posedge clk);
            #1;
        end
    endtask

    // ==================================================
    // Host model and output monitors
    // ==================================================

    task automatic check_read_request();
        t_mdata pt_tag;
        int     due;
        pt_tag = '0;
        pt_tag[MDATA_PT_BIT] = 1'b1;
        if (fiu_rd_mdata[MDATA_PT_BIT])
        begin
            if (exp_pt_rd_addr.size() == 0)
            begin
                report_failure("walker read on the host bus with none outstanding");
            end
            else
            begin
                check_value("fiu_rd_mdata", fiu_rd_mdata, pt_tag);
                check_value("fiu_rd_addr", fiu_rd_addr, exp_pt_rd_addr[0]);
                exp_pt_rsp_addr.push_back(exp_pt_rd_addr.pop_front());
            end
        end
        else if (exp_afu_rd_addr.size() == 0)
        begin
            report_failure("AFU read on the host bus with none outstanding");
        end
        else
        begin
            check_value("fiu_rd_addr", fiu_rd_addr, exp_afu_rd_addr[0]);
            check_value("fiu_rd_mdata", fiu_rd_mdata, exp_afu_rd_mdata[0]);
            exp_afu_rsp_addr.push_back(exp_afu_rd_addr.pop_front());
            exp_afu_rsp_mdata.push_back(exp_afu_rd_mdata.pop_front());
        end
        // The host answers after a random delay and never reorders
        due = cycle + 1 + int'($urandom % 6);
        if (due <= last_due)
        begin
            due = last_due + 1;
        end
        last_due = due;
        rsp_addr_q.push_back(fiu_rd_addr);
        rsp_mdata_q.push_back(fiu_rd_mdata);
        rsp_due_q.push_back(due);
    endtask

    task automatic check_responses();
        if (afu_rsp_valid && exp_afu_rsp_addr.size() == 0)
        begin
            report_failure("AFU response with no AFU read outstanding");
        end
        else if (afu_rsp_valid)
        begin
            check_value("afu_rsp_mdata", afu_rsp_mdata, exp_afu_rsp_mdata.pop_front());
            check_value("afu_rsp_data", afu_rsp_data, addr_data(exp_afu_rsp_addr.pop_front()));
        end
        if (pt_rsp_valid && exp_pt_rsp_addr.size() == 0)
        begin
            report_failure("walker response with no walker read outstanding");
        end
        else if (pt_rsp_valid)
        begin
            check_value("pt_rsp_data", pt_rsp_data, addr_data(exp_pt_rsp_addr.pop_front()));
        end
    endtask

    task automatic check_write_flit();
        int last_slot;
        if (exp_flit_addr.size() == 0)
        begin
            report_failure("write flit on the host bus with none expected");
        end
        else
        begin
            check_value("fiu_wr_addr", fiu_wr_addr, exp_flit_addr.pop_front());
            check_value("fiu_wr_sop", fiu_wr_sop, exp_flit_sop.pop_front());
            check_value("fiu_wr_data", fiu_wr_data, exp_flit_data.pop_front());
            last_slot = exp_flit_last_slot.pop_front();
            // The slot may be refilled once its last beat is gone
            if (last_slot >= 0)
            begin
                slot_busy[last_slot] = 1'b0;
            end
        end
    endtask

    task automatic check_free();
        if (exp_free_slot.size() == 0)
        begin
            report_failure("heap slot freed with no write outstanding");
        end
        else
        begin
            check_value("heap_free_slot", heap_free_slot, exp_free_slot.pop_front());
        end
    endtask

    // Outputs are sampled at the edge and host inputs change 1 ns later
    always @(posedge clk)
    begin
        cycle++;
        if (!reset)
        begin
            if (fiu_rd_valid && fiu_rd_ready)
            begin
                check_read_request();
            end
            check_responses();
            if (fiu_wr_valid && fiu_wr_ready)
            begin
                check_write_flit();
            end
            if (heap_free_valid)
            begin
                check_free();
            end
        end
        #1;
        fiu_rd_ready = ($urandom % 100) < 70;
        fiu_wr_ready = ($urandom % 100) < wr_ready_pct;
        fiu_rsp_valid = 1'b0;
        if (rsp_due_q.size() != 0 && rsp_due_q[0] <= cycle)
        begin
            fiu_rsp_valid = 1'b1;
            fiu_rsp_mdata = rsp_mdata_q.pop_front();
            fiu_rsp_data = addr_data(rsp_addr_q.pop_front());
            last_due = rsp_due_q.pop_front();
        end
    end

    // ==================================================
    // Stimulus
    // ==================================================

    task automatic send_afu_read();
        t_line_addr addr;
        t_mdata     mdata;
        addr = $urandom;
        // The reserved walker bit stays clear on AFU reads
        mdata = t_mdata'($urandom) & 16'h7fff;
        exp_afu_rd_addr.push_back(addr);
        exp_afu_rd_mdata.push_back(mdata);
        afu_rd_valid = 1'b1;
        afu_rd_addr = addr;
        afu_rd_mdata = mdata;
        @(posedge clk);
        while (!afu_rd_ready)
        begin
            @(posedge clk);
        end
        #1;
        afu_rd_valid = 1'b0;
    endtask

    task automatic send_pt_read();
        t_line_addr addr;
        addr = $urandom;
        exp_pt_rd_addr.push_back(addr);
        pt_rd_valid = 1'b1;
        pt_rd_addr = addr;
        @(posedge clk);
        while (!pt_rd_ready)
        begin
            @(posedge clk);
        end
        #1;
        pt_rd_valid = 1'b0;
    endtask

    // Fill a free slot in the heap, then issue the request that names it
    task automatic send_write(input t_beat len);
        t_heap_slot  slot;
        t_line_addr  addr;
        t_wr_payload payload;
        t_line       data;
        slot = t_heap_slot'($urandom);
        while (slot_busy[slot])
        begin
            idle_cycles(1);
            slot = t_heap_slot'($urandom);
        end
        slot_busy[slot] = 1'b1;
        for (int k = 0; k <= int'(len); k++)
        begin
            data = {$urandom, $urandom};
            heap_img[{slot, t_beat'(k)}] = data;
            heap_wr_en = 1'b1;
            heap_wr_slot = slot;
            heap_wr_beat = t_beat'(k);
            heap_wr_data = data;
            idle_cycles(1);
        end
        heap_wr_en = 1'b0;
        // Heap writes land a cycle late and must settle before acceptance
        idle_cycles(2);
        addr = $urandom;
        addr[BEAT_BITS-1:0] = addr[BEAT_BITS-1:0] & ~len;
        // Random pad bits above the slot must be ignored
        payload.line = {$urandom, $urandom};
        payload.slot_view.slot = slot;
        expect_write(slot, addr, len);
        afu_wr_valid = 1'b1;
        afu_wr_addr = addr;
        afu_wr_len = len;
        afu_wr_payload = payload;
        @(posedge clk);
        while (!afu_wr_ready)
        begin
            @(posedge clk);
        end
        #1;
        afu_wr_valid = 1'b0;
    endtask

    // Waits until every expected item has been seen, then a few quiet cycles
    task automatic finish_test(input string name);
        while (!(model_drained() && rsp_due_q.size() == 0))
        begin
            idle_cycles(1);
        end
        idle_cycles(4);
        $display("Test %0d, %s: %0d errors", test_num, name, errors - test_err_start);
        test_num++;
        test_err_start = errors;
    endtask

    initial
    begin
        void'($urandom(32'hf2b7));
        repeat (3)
        begin
            @(posedge clk);
        end
        #1;
        reset = 1'b0;

        repeat (N_AFU_RD)
        begin
            send_afu_read();
            idle_cycles(int'($urandom % 3));
        end
        finish_test("AFU reads");

        // Walker reads compete with a back to back AFU stream
        fork
            begin
                repeat (N_MIX_RD)
                begin
                    send_afu_read();
                end
            end
            begin
                repeat (N_PT_RD)
                begin
                    idle_cycles(int'($urandom % 6));
                    send_pt_read();
                end
            end
        join
        finish_test("walker reads");

        repeat (N_SINGLE_WR)
        begin
            send_write(2'd0);
        end
        finish_test("single beat writes");

        for (int i = 0; i < N_MULTI_WR; i++)
        begin
            send_write((i % 2 == 0) ? 2'd1 : 2'd3);
        end
        finish_test("multi beat writes");

        wr_ready_pct = 50;
        repeat (N_STRESS_WR)
        begin
            send_write(t_beat'($urandom));
        end
        finish_test("write back-pressure");

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
        begin
            $display("Done: no errors");
        end
        else
        begin
            $display("Done: errors found");
        end
        $finish;
    end

    // Watchdog sized from the transaction count of all tests
    initial
    begin
        #(TOTAL_TXNS * TXN_CYCLES * CLK_PERIOD);
        $display("Watchdog expired with transactions still outstanding");
        $display("Done: errors found");
        $finish;
    end

endmodule

//--- src/edge_fiu.sv
// Host side memory edge

`timescale 1ns/1ps

module edge_fiu
    import mem_bus_pkg::*;
    import write_heap_pkg::*;
(
    input  logic        clk,
    input  logic        reset,

    // ==================================================
    // Read path
    // ==================================================

    input  logic        afu_rd_valid,
    output logic        afu_rd_ready,
    input  t_line_addr  afu_rd_addr,
    input  t_mdata      afu_rd_mdata,

    input  logic        pt_rd_valid,
    output logic        pt_rd_ready,
    input  t_line_addr  pt_rd_addr,

    output logic        fiu_rd_valid,
    input  logic        fiu_rd_ready,
    output t_line_addr  fiu_rd_addr,
    output t_mdata      fiu_rd_mdata,

    input  logic        fiu_rsp_valid,
    input  t_mdata      fiu_rsp_mdata,
    input  t_line       fiu_rsp_data,

    output logic        afu_rsp_valid,
    output t_mdata      afu_rsp_mdata,
    output t_line       afu_rsp_data,

    output logic        pt_rsp_valid,
    output t_line       pt_rsp_data,

    // ==================================================
    // Write path
    // ==================================================

    input  logic        heap_wr_en,
    input  t_heap_slot  heap_wr_slot,
    input  t_beat       heap_wr_beat,
    input  t_line       heap_wr_data,

    input  logic        afu_wr_valid,
    output logic        afu_wr_ready,
    input  t_line_addr  afu_wr_addr,
    input  t_beat       afu_wr_len,
    input  t_wr_payload afu_wr_payload,

    output logic        fiu_wr_valid,
    input  logic        fiu_wr_ready,
    output t_line_addr  fiu_wr_addr,
    output logic        fiu_wr_sop,
    output t_line       fiu_wr_data,

    output logic        heap_free_valid,
    output t_heap_slot  heap_free_slot
);

    // Heap read port between the sequencer and the RAM
    logic       heap_rd_en;
    t_heap_addr heap_rd_addr;
    t_line      heap_rd_data;

    read_channel read_channel_i (
        .clk, .reset,
        .afu_rd_valid, .afu_rd_ready, .afu_rd_addr, .afu_rd_mdata,
        .pt_rd_valid, .pt_rd_ready, .pt_rd_addr,
        .fiu_rd_valid, .fiu_rd_ready, .fiu_rd_addr, .fiu_rd_mdata,
        .fiu_rsp_valid, .fiu_rsp_mdata, .fiu_rsp_data,
        .afu_rsp_valid, .afu_rsp_mdata, .afu_rsp_data,
        .pt_rsp_valid, .pt_rsp_data
    );

    write_heap write_heap_i (
        .clk, .reset,
        .wr_en(heap_wr_en),
        .wr_slot(heap_wr_slot),
        .wr_beat(heap_wr_beat),
        .wr_data(heap_wr_data),
        .rd_en(heap_rd_en),
        .rd_addr(heap_rd_addr),
        .rd_data(heap_rd_data)
    );

    write_beat_sequencer write_beat_sequencer_i (
        .clk, .reset,
        .afu_wr_valid, .afu_wr_ready, .afu_wr_addr, .afu_wr_len, .afu_wr_payload,
        .fiu_wr_valid, .fiu_wr_ready, .fiu_wr_addr, .fiu_wr_sop, .fiu_wr_data,
        .heap_rd_en, .heap_rd_addr, .heap_rd_data,
        .heap_free_valid, .heap_free_slot
    );

endmodule

//--- src/write_beat_sequencer.sv
// Write beat sequencer

`timescale 1ns/1ps

module write_beat_sequencer
    import mem_bus_pkg::*;
    import write_heap_pkg::*;
(
    input  logic        clk,
    input  logic        reset,

    // Write requests whose data word names the heap slot
    input  logic        afu_wr_valid,
    output logic        afu_wr_ready,
    input  t_line_addr  afu_wr_addr,
    input  t_beat       afu_wr_len,
    input  t_wr_payload afu_wr_payload,

    // One flit per beat toward the host
    output logic        fiu_wr_valid,
    input  logic        fiu_wr_ready,
    output t_line_addr  fiu_wr_addr,
    output logic        fiu_wr_sop,
    output t_line       fiu_wr_data,

    // Heap read port
    output logic        heap_rd_en,
    output t_heap_addr  heap_rd_addr,
    input  t_line       heap_rd_data,

    // Slot release once the last beat is on its way
    output logic        heap_free_valid,
    output t_heap_slot  heap_free_slot
);

    // ==================================================
    // Pipeline control
    // ==================================================

    logic advance;
    logic accept;

    // Stage 1 walks the beats of the current packet
    logic       stg1_valid;
    t_line_addr stg1_addr;
    t_heap_slot stg1_slot;
    t_beat      stg1_beat;
    t_beat      stg1_rem;
    logic       stg1_done;

    // Stages 2 and 3 carry finished flit headers
    logic       stg2_valid;
    t_line_addr stg2_addr;
    logic       stg2_sop;
    logic       stg3_valid;
    t_line_addr stg3_addr;
    logic       stg3_sop;

    // The whole pipeline moves together, unless the host holds stage 3
    assign advance = fiu_wr_ready || !stg3_valid;

    // Last beat of the packet is the one in stage 1 now
    assign stg1_done = (stg1_rem == '0);

    // A new packet may start only once the current one has issued its last beat
    assign afu_wr_ready = advance && (!stg1_valid || stg1_done);
    assign accept = afu_wr_valid && afu_wr_ready;

    // ==================================================
    // Stage 1 beat counting and heap addressing
    // ==================================================

    always_ff @(posedge clk)
    begin
        if (advance)
        begin
            if (accept)
            begin
                stg1_valid <= 1'b1;
                stg1_addr <= afu_wr_addr;
                stg1_slot <= afu_wr_payload.slot_view.slot;
                stg1_beat <= '0;
                stg1_rem <= afu_wr_len;
            end
            else if (stg1_valid && !stg1_done)
            begin
                // Middle of a multi-beat packet
                stg1_beat <= stg1_beat + 1'b1;
                stg1_rem <= stg1_rem - 1'b1;
            end
            else
            begin
                stg1_valid <= 1'b0;
            end
        end

        if (reset)
        begin
            stg1_valid <= 1'b0;
            stg1_beat <= '0;
            stg1_rem <= '0;
        end
    end

    // The heap read starts here, two stages ahead of the data it returns
    assign heap_rd_en = advance;
    assign heap_rd_addr = {stg1_slot, stg1_beat};

    // ==================================================
    // Stages 2 and 3
    // ==================================================

    always_ff @(posedge clk)
    begin
        if (advance)
        begin
            stg2_valid <= stg1_valid;
            // SOP belongs to the first beat only
            stg2_sop <= (stg1_beat == '0);
            // The base address is aligned, so the beat just fills the low bits
            stg2_addr <= {stg1_addr[LINE_ADDR_BITS-1:BEAT_BITS],
                          stg1_addr[BEAT_BITS-1:0] | stg1_beat};

            stg3_valid <= stg2_valid;
            stg3_sop <= stg2_sop;
            stg3_addr <= stg2_addr;
        end

        // Free the slot once its last beat has moved into stage 2
        heap_free_valid <= advance && stg1_valid && stg1_done;
        heap_free_slot <= stg1_slot;

        if (reset)
        begin
            stg2_valid <= 1'b0;
            stg3_valid <= 1'b0;
            heap_free_valid <= 1'b0;
        end
    end

    // Stage 3 meets the heap data
    assign fiu_wr_valid = stg3_valid;
    assign fiu_wr_addr = stg3_addr;
    assign fiu_wr_sop = stg3_sop;
    assign fiu_wr_data = heap_rd_data;

    // Multi-beat writes must start on a boundary of their own size
    wr_addr_aligned: assert property (@(posedge clk) disable iff (reset)
        afu_wr_valid |-> ((afu_wr_addr[BEAT_BITS-1:0] & afu_wr_len) == '0));

endmodule

//--- src/write_heap.sv
// Write data heap RAM

`timescale 1ns/1ps

module write_heap
    import mem_bus_pkg::*;
    import write_heap_pkg::*;
(
    input  logic       clk,
    input  logic       reset,

    // Write port, fed directly by the AFU side
    input  logic       wr_en,
    input  t_heap_slot wr_slot,
    input  t_beat      wr_beat,
    input  t_line      wr_data,

    // Read port, stepped by the beat sequencer pipeline
    input  logic       rd_en,
    input  t_heap_addr rd_addr,
    output t_line      rd_data
);

    t_line mem [HEAP_LINES];

    // Write port registers
    logic       wr_en_q;
    t_heap_addr wr_addr_q;
    t_line      wr_data_q;

    // Read port registers
    t_heap_addr rd_addr_q;
    t_line      rd_data_q;

    // Incoming writes are registered first, so a line lands one cycle late
    always_ff @(posedge clk)
    begin
        wr_en_q <= wr_en;
        wr_addr_q <= {wr_slot, wr_beat};
        wr_data_q <= wr_data;

        if (wr_en_q)
        begin
            mem[wr_addr_q] <= wr_data_q;
        end

        if (reset)
        begin
            wr_en_q <= 1'b0;
        end
    end

    // Both read stages hold while the sequencer is stalled.
    // The data then stays lined up with the request sitting in stage 3
    always_ff @(posedge clk)
    begin
        if (rd_en)
        begin
            rd_addr_q <= rd_addr;
            rd_data_q <= mem[rd_addr_q];
        end
    end

    assign rd_data = rd_data_q;

endmodule

//--- src/read_channel.sv
// Shared read channel

`timescale 1ns/1ps

module read_channel
    import mem_bus_pkg::*;
(
    input  logic       clk,
    input  logic       reset,

    // Read requests from the AFU
    input  logic       afu_rd_valid,
    output logic       afu_rd_ready,
    input  t_line_addr afu_rd_addr,
    input  t_mdata     afu_rd_mdata,

    // Read requests from the page table walker
    input  logic       pt_rd_valid,
    output logic       pt_rd_ready,
    input  t_line_addr pt_rd_addr,

    // Shared read request bus toward the host
    output logic       fiu_rd_valid,
    input  logic       fiu_rd_ready,
    output t_line_addr fiu_rd_addr,
    output t_mdata     fiu_rd_mdata,

    // Read responses from the host
    input  logic       fiu_rsp_valid,
    input  t_mdata     fiu_rsp_mdata,
    input  t_line      fiu_rsp_data,

    // Steered responses
    output logic       afu_rsp_valid,
    output t_mdata     afu_rsp_mdata,
    output t_line      afu_rsp_data,
    output logic       pt_rsp_valid,
    output t_line      pt_rsp_data
);

    // ==================================================
    // Walker request holder
    // ==================================================

    logic       pt_held;
    logic       pt_held_next;
    t_line_addr pt_addr;
    t_mdata     pt_tag;

    // A held request stays until the host bus takes it
    assign pt_held_next = (pt_held && !fiu_rd_ready) || (pt_rd_valid && pt_rd_ready);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            pt_held <= 1'b0;
            // Ready stays low through reset and rises once the holder is known empty
            pt_rd_ready <= 1'b0;
        end
        else
        begin
            pt_held <= pt_held_next;
            pt_rd_ready <= !pt_held_next;
        end

        if (pt_rd_valid && pt_rd_ready)
        begin
            pt_addr <= pt_rd_addr;
        end
    end

    // Walker reads carry nothing in the tag but the reserved bit
    always_comb
    begin
        pt_tag = '0;
        pt_tag[MDATA_PT_BIT] = 1'b1;
    end

    // ==================================================
    // Arbitration, walker first
    // ==================================================

    assign fiu_rd_valid = pt_held || afu_rd_valid;
    assign fiu_rd_addr = pt_held ? pt_addr : afu_rd_addr;
    assign fiu_rd_mdata = pt_held ? pt_tag : afu_rd_mdata;

    // The AFU only moves when the walker has nothing waiting
    assign afu_rd_ready = !pt_held && fiu_rd_ready;

    // ==================================================
    // Response routing
    // ==================================================

    // Responses are split by the echoed reserved bit in the same cycle
    assign pt_rsp_valid = fiu_rsp_valid && fiu_rsp_mdata[MDATA_PT_BIT];
    assign pt_rsp_data = fiu_rsp_data;

    assign afu_rsp_valid = fiu_rsp_valid && !fiu_rsp_mdata[MDATA_PT_BIT];
    assign afu_rsp_mdata = fiu_rsp_mdata;
    assign afu_rsp_data = fiu_rsp_data;

    // The AFU must never claim the walker's tag bit, or its responses go astray
    afu_tag_free: assert property (@(posedge clk) disable iff (reset)
        afu_rd_valid |-> !afu_rd_mdata[MDATA_PT_BIT]);

endmodule

//--- src/write_heap_pkg.sv
// Write heap sizing and payload

package write_heap_pkg;

    import mem_bus_pkg::*;

    // Number of logical slots handed out for write data
    localparam int HEAP_SLOTS = 8;

    localparam int HEAP_SLOT_BITS = $clog2(HEAP_SLOTS);

    typedef logic [HEAP_SLOT_BITS-1:0] t_heap_slot;

    // Each slot reserves room for a full multi-beat packet
    localparam int HEAP_LINES = HEAP_SLOTS * MAX_BEATS;

    localparam int HEAP_ADDR_BITS = $clog2(HEAP_LINES);

    // Heap address is the slot in the high bits and the beat in the low bits
    typedef logic [HEAP_ADDR_BITS-1:0] t_heap_addr;

    // The data word of a write request.
    // Upstream it is a line, here only the slot number in its low bits matters
    typedef union packed {
        t_line line;
        struct packed {
            logic [LINE_BITS-HEAP_SLOT_BITS-1:0] pad;
            t_heap_slot slot;
        } slot_view;
    } t_wr_payload;

endpackage

//--- src/mem_bus_pkg.sv
// Host memory bus formats

package mem_bus_pkg;

    // ==================================================
    // Data lines
    // ==================================================

    // Width of one cache line moved on the host bus
    localparam int LINE_BITS = 64;

    typedef logic [LINE_BITS-1:0] t_line;

    // Line addresses count lines, not bytes
    localparam int LINE_ADDR_BITS = 32;

    typedef logic [LINE_ADDR_BITS-1:0] t_line_addr;

    // ==================================================
    // Request metadata
    // ==================================================

    // The metadata tag is echoed unchanged by the host on read responses
    localparam int MDATA_BITS = 16;

    typedef logic [MDATA_BITS-1:0] t_mdata;

    // Reserved tag bit owned by the page table walker.
    // AFU reads must leave it clear so responses can be steered by it alone
    localparam int MDATA_PT_BIT = 15;

    // ==================================================
    // Multi-beat packets
    // ==================================================

    // A write packet carries up to this many lines
    localparam int MAX_BEATS = 4;

    localparam int BEAT_BITS = $clog2(MAX_BEATS);

    // Holds either a beat number inside a packet or a length minus one
    typedef logic [BEAT_BITS-1:0] t_beat;

endpackage
